//--- usb3_link_pkg.sv
//////////////////////////////
// shared constants and the link command type of the usb3 link layer
// design files refer to these by scoped names
//////////////////////////////
`default_nettype none

package usb3_link_pkg;

	// 11-bit link command, read as raw, as an LGOOD or as an LCRD
	typedef union packed {
		logic [10:0] raw;
		struct packed {
			logic [7:0] cls;
			logic [2:0] seq;
		} lgood;
		struct packed {
			logic [8:0] cls;
			logic [1:0] idx;
		} lcrd;
	} lcmd_t;

	//////////////////////////////
	// link command codes
	//////////////////////////////
	localparam logic [10:0] LCMD_LGOOD_0 = 11'h000;
	localparam logic [10:0] LCMD_LCRD_A  = 11'h008;
	localparam logic [10:0] LCMD_LRTY    = 11'h010;
	localparam logic [10:0] LCMD_LBAD    = 11'h018;
	localparam logic [10:0] LCMD_LUP     = 11'h100;
	localparam logic [10:0] LCMD_LDN     = 11'h101;

	// class bits shared by all LGOOD_n and all LCRD_x
	localparam logic [7:0] LGOOD_CLASS = LCMD_LGOOD_0[10:3];
	localparam logic [8:0] LCRD_CLASS  = LCMD_LCRD_A[10:2];

	// ordered set that opens a link command
	localparam logic [31:0] OS_LCMD   = 32'hFEFEFEF7;
	localparam logic [3:0]  OS_LCMD_K = 4'b1111;

	//////////////////////////////
	// LTSSM state codes
	//////////////////////////////
	localparam logic [4:0] LT_POLLING_IDLE  = 5'd10;
	localparam logic [4:0] LT_U0            = 5'd16;
	localparam logic [4:0] LT_RECOVERY_IDLE = 5'd20;
	localparam logic [4:0] LT_HOTRESET_EXIT = 5'd24;

	// timeouts in local_clk cycles
	// idle transmit time before a keepalive LUP
	localparam logic [24:0] U0L_TIMEOUT_CYCLES = 25'd1250;
	// receive silence before recovery is requested
	localparam logic [24:0] U0_RECOVERY_CYCLES = 25'd125000;
	// settle time after U0 entry before the advertisement
	localparam logic [5:0]  ADV_DELAY_CYCLES   = 6'd40;

	// header credits held by each side
	localparam logic [2:0] MAX_CREDITS = 3'd4;

endpackage

`default_nettype wire

//--- usb3_crc_cw.sv
//////////////////////////////
// CRC-5 over an 11-bit link command, used on both the receive and transmit side
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module usb3_crc_cw (
	input  wire  [10:0] data_in,
	output logic [4:0]  crc_out
);

	logic [4:0] lfsr;
	logic       fb;

	// x^5 + x^2 + 1, seeded with ones, bit 0 shifted in first
	always_comb begin
		lfsr = 5'h1f;
		fb   = 1'b0;
		for (int i = 0; i < 11; i++) begin
			fb   = lfsr[4] ^ data_in[i];
			lfsr = {lfsr[3:0], 1'b0} ^ {2'b00, fb, 1'b0, fb};
		end
		// remainder goes out inverted
		crc_out = ~lfsr;
	end

endmodule

`default_nettype wire

//--- usb3_lcmd_rx.sv
//////////////////////////////
// link command receiver on the PIPE word stream
// finds the ordered set in U0, captures the command word and checks both copies
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module usb3_lcmd_rx (
	input  wire                  local_clk,
	input  wire                  reset_n,
	input  wire  [4:0]           ltssm_state,
	input  wire  [31:0]          in_data,
	input  wire  [3:0]           in_datak,
	input  wire                  in_active,
	output logic                 rx_os_seen,
	output usb3_link_pkg::lcmd_t rx_cmd,
	output logic                 rx_cmd_valid
);

	logic        wait_cmdw;
	logic        is_os;
	logic [31:0] in_swap;
	logic [31:0] cmdw;
	logic        cmdw_valid;
	logic [4:0]  crc_hi;
	logic [4:0]  crc_lo;
	logic        cmdw_ok;

	assign is_os = in_active && in_data == usb3_link_pkg::OS_LCMD &&
		in_datak == usb3_link_pkg::OS_LCMD_K;

	// bytes of each 16-bit half arrive swapped
	assign in_swap = {in_data[23:16], in_data[31:24], in_data[7:0], in_data[15:8]};

	//////////////////////////////
	// capture
	always_ff @(posedge local_clk) begin
		if (!reset_n) begin
			wait_cmdw  <= 1'b0;
			rx_os_seen <= 1'b0;
			cmdw_valid <= 1'b0;
		end else begin
			rx_os_seen <= 1'b0;
			cmdw_valid <= 1'b0;
			if (ltssm_state != usb3_link_pkg::LT_U0) begin
				wait_cmdw <= 1'b0;
			end else if (!wait_cmdw) begin
				if (is_os) begin
					wait_cmdw  <= 1'b1;
					rx_os_seen <= 1'b1;
				end
			end else if (in_active) begin
				// idle gaps before the word are skipped
				cmdw       <= in_swap;
				cmdw_valid <= 1'b1;
				wait_cmdw  <= 1'b0;
			end
		end
	end

	usb3_crc_cw u_crc_hi (
		.data_in (cmdw[26:16]),
		.crc_out (crc_hi)
	);

	usb3_crc_cw u_crc_lo (
		.data_in (cmdw[10:0]),
		.crc_out (crc_lo)
	);

	// both copies equal and both CRCs good
	assign cmdw_ok = cmdw[26:16] == cmdw[10:0] && crc_hi == cmdw[31:27] &&
		crc_lo == cmdw[15:11];

	//////////////////////////////
	// validate
	always_ff @(posedge local_clk) begin
		if (!reset_n) begin
			rx_cmd_valid <= 1'b0;
		end else begin
			rx_cmd_valid <= cmdw_valid && cmdw_ok;
			rx_cmd.raw   <= cmdw[10:0];
		end
	end

	a_rx_valid_spaced: assert property (@(posedge local_clk) disable iff (!reset_n)
		rx_cmd_valid |=> !rx_cmd_valid)
		else $error("rx_cmd_valid high in two consecutive cycles");

endmodule

`default_nettype wire

//--- usb3_lcmd_tx.sv
//////////////////////////////
// link command transmitter, sends the ordered set and then the command word
// one tx_start gives two output words and a tx_done on the second
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module usb3_lcmd_tx (
	input  wire                  local_clk,
	input  wire                  reset_n,
	input  wire usb3_link_pkg::lcmd_t tx_cmd,
	input  wire                  tx_start,
	output logic                 tx_busy,
	output logic                 tx_done,
	output logic [31:0]          out_data,
	output logic [3:0]           out_datak,
	output logic                 out_active
);

	usb3_link_pkg::lcmd_t cmd_q;
	logic                 send_cw;
	logic [4:0]           crc;
	logic [15:0]          half_swap;

	usb3_crc_cw u_crc (
		.data_in (cmd_q.raw),
		.crc_out (crc)
	);

	// {crc, cmd} with its two bytes swapped for the wire
	assign half_swap = {cmd_q.raw[7:0], crc, cmd_q.raw[10:8]};

	// ordered set is on the output while the word is being prepared
	assign tx_busy = send_cw;

	always_ff @(posedge local_clk) begin
		if (tx_start) begin
			cmd_q <= tx_cmd;
		end
	end

	//////////////////////////////
	// output stream
	always_ff @(posedge local_clk) begin
		if (!reset_n) begin
			send_cw    <= 1'b0;
			tx_done    <= 1'b0;
			out_data   <= 32'h0;
			out_datak  <= 4'b0000;
			out_active <= 1'b0;
		end else begin
			send_cw    <= tx_start;
			tx_done    <= send_cw;
			out_data   <= 32'h0;
			out_datak  <= 4'b0000;
			out_active <= 1'b0;
			if (tx_start) begin
				out_data   <= usb3_link_pkg::OS_LCMD;
				out_datak  <= usb3_link_pkg::OS_LCMD_K;
				out_active <= 1'b1;
			end else if (send_cw) begin
				// command word carries two identical copies
				out_data   <= {half_swap, half_swap};
				out_active <= 1'b1;
			end
		end
	end

	a_tx_start_idle: assert property (@(posedge local_clk) disable iff (!reset_n)
		tx_start |-> !tx_busy)
		else $error("tx_start while transmitter busy");

endmodule

`default_nettype wire

//--- usb3_link_timers.sv
//////////////////////////////
// U0 keepalive and recovery timers that pause outside U0
// link control hears from them through lup_due and recovery_due
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module usb3_link_timers (
	input  wire        local_clk,
	input  wire        reset_n,
	input  wire  [4:0] ltssm_state,
	input  wire        u0_entry,
	input  wire        rx_os_seen,
	input  wire        tx_done,
	output logic       lup_due,
	output logic       recovery_due
);

	logic [24:0] u0l_cnt;
	logic [24:0] rec_cnt;
	logic        in_u0;

	assign in_u0 = ltssm_state == usb3_link_pkg::LT_U0;

	always_ff @(posedge local_clk) begin
		if (!reset_n) begin
			u0l_cnt      <= 25'd0;
			rec_cnt      <= 25'd0;
			lup_due      <= 1'b0;
			recovery_due <= 1'b0;
		end else begin
			recovery_due <= 1'b0;

			// any sent command restarts the keepalive count
			if (tx_done || u0_entry) begin
				u0l_cnt <= 25'd0;
				lup_due <= 1'b0;
			end else if (in_u0) begin
				if (u0l_cnt == usb3_link_pkg::U0L_TIMEOUT_CYCLES)
					lup_due <= 1'b1;
				else
					u0l_cnt <= u0l_cnt + 25'd1;
			end

			// far-end silence count saturates after one pulse
			if (rx_os_seen || u0_entry) begin
				rec_cnt <= 25'd0;
			end else if (in_u0 && rec_cnt != usb3_link_pkg::U0_RECOVERY_CYCLES) begin
				rec_cnt <= rec_cnt + 25'd1;
				if (rec_cnt == usb3_link_pkg::U0_RECOVERY_CYCLES - 25'd1)
					recovery_due <= 1'b1;
			end
		end
	end

	a_recovery_in_u0: assert property (@(posedge local_clk) disable iff (!reset_n)
		recovery_due |-> in_u0)
		else $error("recovery_due raised outside U0");

endmodule

`default_nettype wire

//--- usb3_link_ctrl.sv
//////////////////////////////
// link control: LTSSM tracking, U0 advertisement, transmit choice,
// remote credits, LGOOD order and sticky error flags
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module usb3_link_ctrl (
	input  wire                  local_clk,
	input  wire                  reset_n,
	input  wire  [4:0]           ltssm_state,
	input  wire usb3_link_pkg::lcmd_t rx_cmd,
	input  wire                  rx_cmd_valid,
	input  wire                  tx_busy,
	input  wire                  tx_done,
	input  wire                  lup_due,
	input  wire                  recovery_due,
	output logic                 u0_entry,
	output usb3_link_pkg::lcmd_t tx_cmd,
	output logic                 tx_start,
	output logic [2:0]           tx_credits,
	output logic                 ltssm_go_recovery,
	output logic                 err_lcmd_undefined,
	output logic                 err_lcrd_mismatch,
	output logic                 err_lgood_order
);

	logic [4:0] ltssm_last;
	logic       in_u0;
	logic       enter_u0;
	logic       tx_idle;
	logic       adv_wait;
	logic [5:0] adv_delay;
	logic       adv_run;
	logic       adv_inflight;
	logic [2:0] adv_step;
	logic       seq_synced;
	logic [2:0] seq_expect;
	logic       is_lgood;
	logic       is_lcrd;
	logic       is_plain;

	assign in_u0    = ltssm_state == usb3_link_pkg::LT_U0;
	assign enter_u0 = in_u0 && ltssm_last != ltssm_state;
	// no new command in the cycles the transmitter is still working on one
	assign tx_idle  = !tx_busy && !tx_start && !tx_done;

	assign is_lgood = rx_cmd.lgood.cls == usb3_link_pkg::LGOOD_CLASS;
	assign is_lcrd  = rx_cmd.lcrd.cls == usb3_link_pkg::LCRD_CLASS;
	assign is_plain = rx_cmd.raw inside {usb3_link_pkg::LCMD_LRTY, usb3_link_pkg::LCMD_LBAD,
		usb3_link_pkg::LCMD_LUP, usb3_link_pkg::LCMD_LDN};

	always_ff @(posedge local_clk) begin
		if (!reset_n) begin
			ltssm_last         <= ltssm_state;
			u0_entry           <= 1'b0;
			tx_start           <= 1'b0;
			tx_credits         <= 3'd0;
			ltssm_go_recovery  <= 1'b0;
			err_lcmd_undefined <= 1'b0;
			err_lcrd_mismatch  <= 1'b0;
			err_lgood_order    <= 1'b0;
			adv_wait           <= 1'b0;
			adv_delay          <= 6'd0;
			adv_run            <= 1'b0;
			adv_inflight       <= 1'b0;
			adv_step           <= 3'd0;
			seq_synced         <= 1'b0;
			seq_expect         <= 3'd0;
		end else begin
			ltssm_last <= ltssm_state;
			u0_entry   <= enter_u0;
			tx_start   <= 1'b0;

			//////////////////////////////
			// transmit choice, advertisement before LUP
			if (in_u0 && tx_idle) begin
				if (adv_run && !adv_inflight) begin
					tx_start     <= 1'b1;
					adv_inflight <= 1'b1;
					if (adv_step == 3'd0) begin
						tx_cmd.lgood.cls <= usb3_link_pkg::LGOOD_CLASS;
						tx_cmd.lgood.seq <= 3'd7;
					end else begin
						// steps 1..4 map to LCRD_A..LCRD_D
						tx_cmd.lcrd.cls <= usb3_link_pkg::LCRD_CLASS;
						tx_cmd.lcrd.idx <= adv_step[1:0] - 2'd1;
					end
				end else if (lup_due) begin
					tx_start   <= 1'b1;
					tx_cmd.raw <= usb3_link_pkg::LCMD_LUP;
				end
			end

			if (tx_done && adv_inflight) begin
				adv_inflight <= 1'b0;
				adv_step     <= adv_step + 3'd1;
				if (adv_step == 3'd4)
					adv_run <= 1'b0;
			end

			// settle delay before the advertisement
			if (adv_wait) begin
				if (adv_delay == usb3_link_pkg::ADV_DELAY_CYCLES) begin
					adv_wait <= 1'b0;
					adv_run  <= 1'b1;
				end else begin
					adv_delay <= adv_delay + 6'd1;
				end
			end

			//////////////////////////////
			// received commands
			if (rx_cmd_valid) begin
				if (is_lgood) begin
					if (!seq_synced) begin
						seq_synced <= 1'b1;
						seq_expect <= rx_cmd.lgood.seq + 3'd1;
					end else if (rx_cmd.lgood.seq == seq_expect) begin
						seq_expect <= seq_expect + 3'd1;
					end else begin
						err_lgood_order   <= 1'b1;
						ltssm_go_recovery <= 1'b1;
					end
				end else if (is_lcrd) begin
					if (tx_credits == usb3_link_pkg::MAX_CREDITS)
						err_lcrd_mismatch <= 1'b1;
					else
						tx_credits <= tx_credits + 3'd1;
				end else if (!is_plain) begin
					err_lcmd_undefined <= 1'b1;
				end
			end

			if (recovery_due)
				ltssm_go_recovery <= 1'b1;

			//////////////////////////////
			// LTSSM changes, override the above
			if (enter_u0) begin
				tx_credits   <= 3'd0;
				adv_wait     <= 1'b1;
				adv_delay    <= 6'd0;
				adv_run      <= 1'b0;
				adv_inflight <= 1'b0;
				adv_step     <= 3'd0;
				seq_synced   <= 1'b0;
				// state is lost only after training or hot reset
				if (ltssm_last == usb3_link_pkg::LT_POLLING_IDLE ||
					ltssm_last == usb3_link_pkg::LT_HOTRESET_EXIT)
					seq_expect <= 3'd0;
			end else if (!in_u0) begin
				adv_wait     <= 1'b0;
				adv_run      <= 1'b0;
				adv_inflight <= 1'b0;
			end

			if (ltssm_state == usb3_link_pkg::LT_RECOVERY_IDLE && ltssm_last != ltssm_state)
				ltssm_go_recovery <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- usb3_link.sv
//////////////////////////////
// usb3 link layer top, link command half
// connects the PIPE word stream and LTSSM to receive, transmit, timers and control
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module usb3_link (
	input  wire         local_clk,
	input  wire         reset_n,
	input  wire  [4:0]  ltssm_state,
	output logic        ltssm_go_recovery,
	// PIPE receive
	input  wire  [31:0] in_data,
	input  wire  [3:0]  in_datak,
	input  wire         in_active,
	// PIPE transmit
	output logic [31:0] out_data,
	output logic [3:0]  out_datak,
	output logic        out_active,
	// status
	output logic [2:0]  tx_credits,
	output logic        err_lcmd_undefined,
	output logic        err_lcrd_mismatch,
	output logic        err_lgood_order
);

	usb3_link_pkg::lcmd_t rx_cmd;
	usb3_link_pkg::lcmd_t tx_cmd;
	logic                 rx_cmd_valid;
	logic                 rx_os_seen;
	logic                 tx_start;
	logic                 tx_busy;
	logic                 tx_done;
	logic                 lup_due;
	logic                 recovery_due;
	logic                 u0_entry;

	usb3_lcmd_rx u_lcmd_rx (
		.local_clk    (local_clk),
		.reset_n      (reset_n),
		.ltssm_state  (ltssm_state),
		.in_data      (in_data),
		.in_datak     (in_datak),
		.in_active    (in_active),
		.rx_os_seen   (rx_os_seen),
		.rx_cmd       (rx_cmd),
		.rx_cmd_valid (rx_cmd_valid)
	);

	usb3_lcmd_tx u_lcmd_tx (
		.local_clk  (local_clk),
		.reset_n    (reset_n),
		.tx_cmd     (tx_cmd),
		.tx_start   (tx_start),
		.tx_busy    (tx_busy),
		.tx_done    (tx_done),
		.out_data   (out_data),
		.out_datak  (out_datak),
		.out_active (out_active)
	);

	usb3_link_timers u_link_timers (
		.local_clk    (local_clk),
		.reset_n      (reset_n),
		.ltssm_state  (ltssm_state),
		.u0_entry     (u0_entry),
		.rx_os_seen   (rx_os_seen),
		.tx_done      (tx_done),
		.lup_due      (lup_due),
		.recovery_due (recovery_due)
	);

	usb3_link_ctrl u_link_ctrl (
		.local_clk          (local_clk),
		.reset_n            (reset_n),
		.ltssm_state        (ltssm_state),
		.rx_cmd             (rx_cmd),
		.rx_cmd_valid       (rx_cmd_valid),
		.tx_busy            (tx_busy),
		.tx_done            (tx_done),
		.lup_due            (lup_due),
		.recovery_due       (recovery_due),
		.u0_entry           (u0_entry),
		.tx_cmd             (tx_cmd),
		.tx_start           (tx_start),
		.tx_credits         (tx_credits),
		.ltssm_go_recovery  (ltssm_go_recovery),
		.err_lcmd_undefined (err_lcmd_undefined),
		.err_lcrd_mismatch  (err_lcrd_mismatch),
		.err_lgood_order    (err_lgood_order)
	);

endmodule

`default_nettype wire

//--- tb_usb3_link.sv
//////////////////////////////
// directed testbench for the usb3 link command layer
// drives the PIPE receive stream and the LTSSM state, checks the transmit stream and status
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_usb3_link;

	logic        local_clk;
	logic        reset_n;
	logic [4:0]  ltssm_state;
	logic [31:0] in_data;
	logic [3:0]  in_datak;
	logic        in_active;
	logic        ltssm_go_recovery;
	logic [31:0] out_data;
	logic [3:0]  out_datak;
	logic        out_active;
	logic [2:0]  tx_credits;
	logic        err_lcmd_undefined;
	logic        err_lcrd_mismatch;
	logic        err_lgood_order;

	integer      seed;
	logic [31:0] rnd;
	logic [2:0]  wrong_seq;

	usb3_link u_usb3_link (
		.local_clk          (local_clk),
		.reset_n            (reset_n),
		.ltssm_state        (ltssm_state),
		.ltssm_go_recovery  (ltssm_go_recovery),
		.in_data            (in_data),
		.in_datak           (in_datak),
		.in_active          (in_active),
		.out_data           (out_data),
		.out_datak          (out_datak),
		.out_active         (out_active),
		.tx_credits         (tx_credits),
		.err_lcmd_undefined (err_lcmd_undefined),
		.err_lcrd_mismatch  (err_lcrd_mismatch),
		.err_lgood_order    (err_lgood_order)
	);

	initial begin
		local_clk = 1'b0;
		forever #10 local_clk = ~local_clk;
	end

	//////////////////////////////
	// expected words
	//////////////////////////////

	// x^5 + x^2 + 1, all-ones seed, bit 0 first, result inverted
	function automatic logic [4:0] calc_crc5(input logic [10:0] cmd);
		logic [4:0] r;
		logic       top;
		r = 5'h1f;
		for (int i = 0; i < 11; i++) begin
			top = r[4] ^ cmd[i];
			r   = r << 1;
			if (top)
				r = r ^ 5'h05;
		end
		return ~r;
	endfunction

	// {crc, cmd} with its two bytes swapped
	function automatic logic [15:0] wire_half(input logic [10:0] cmd);
		logic [15:0] h;
		h = {calc_crc5(cmd), cmd};
		return {h[7:0], h[15:8]};
	endfunction

	function automatic logic [31:0] cmd_word(input logic [10:0] cmd);
		return {wire_half(cmd), wire_half(cmd)};
	endfunction

	function automatic logic [10:0] lgood_code(input int n);
		return usb3_link_pkg::LCMD_LGOOD_0 + 11'(n);
	endfunction

	function automatic logic [10:0] lcrd_code(input int x);
		return usb3_link_pkg::LCMD_LCRD_A + 11'(x);
	endfunction

	//////////////////////////////
	// helpers
	//////////////////////////////

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "testbench stopped at first error");
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge local_clk);
	endtask

	task automatic set_ltssm(input logic [4:0] state);
		@(posedge local_clk);
		ltssm_state <= state;
	endtask

	// ordered set, optional idle gap, then the command word
	task automatic send_lcmd(input logic [31:0] word, input int gap);
		@(posedge local_clk);
		in_data   <= usb3_link_pkg::OS_LCMD;
		in_datak  <= 4'b1111;
		in_active <= 1'b1;
		repeat (gap) begin
			@(posedge local_clk);
			in_data   <= 32'h0;
			in_datak  <= 4'b0000;
			in_active <= 1'b0;
		end
		@(posedge local_clk);
		in_data   <= word;
		in_datak  <= 4'b0000;
		in_active <= 1'b1;
		@(posedge local_clk);
		in_data   <= 32'h0;
		in_active <= 1'b0;
	endtask

	// waits until the status outputs reach the given values, then checks each
	task automatic wait_status(input logic [2:0] credits, input logic undef,
		input logic lcrd_err, input logic order_err, input logic go_rec, input int timeout);
		int waited;
		waited = 0;
		do begin
			@(negedge local_clk);
			waited++;
		end while (waited < timeout && !(tx_credits == credits &&
			err_lcmd_undefined == undef && err_lcrd_mismatch == lcrd_err &&
			err_lgood_order == order_err && ltssm_go_recovery == go_rec));
		assert (tx_credits == credits) else stop_with_error($sformatf(
			"mismatch tx_credits: got %h, expected %h", tx_credits, credits));
		assert (err_lcmd_undefined == undef) else stop_with_error($sformatf(
			"mismatch err_lcmd_undefined: got %h, expected %h", err_lcmd_undefined, undef));
		assert (err_lcrd_mismatch == lcrd_err) else stop_with_error($sformatf(
			"mismatch err_lcrd_mismatch: got %h, expected %h", err_lcrd_mismatch, lcrd_err));
		assert (err_lgood_order == order_err) else stop_with_error($sformatf(
			"mismatch err_lgood_order: got %h, expected %h", err_lgood_order, order_err));
		assert (ltssm_go_recovery == go_rec) else stop_with_error($sformatf(
			"mismatch ltssm_go_recovery: got %h, expected %h", ltssm_go_recovery, go_rec));
	endtask

	// transmit monitor, one ordered set and the word right after it
	task automatic expect_lcmd(input logic [10:0] cmd, input int timeout);
		int   waited;
		logic found;
		waited = 0;
		found  = 1'b0;
		while (!found && waited < timeout) begin
			@(negedge local_clk);
			if (out_active && out_data == usb3_link_pkg::OS_LCMD)
				found = 1'b1;
			else
				waited++;
		end
		assert (found) else stop_with_error($sformatf(
			"no ordered set for command %h within %0d cycles", cmd, timeout));
		assert (out_datak == 4'b1111) else stop_with_error($sformatf(
			"mismatch out_datak: got %h, expected %h", out_datak, 4'b1111));
		@(negedge local_clk);
		assert (out_active) else stop_with_error("command word missing after the ordered set");
		assert (out_datak == 4'b0000) else stop_with_error($sformatf(
			"mismatch out_datak: got %h, expected %h", out_datak, 4'b0000));
		assert (out_data == cmd_word(cmd)) else stop_with_error($sformatf(
			"mismatch out_data: got %h, expected %h", out_data, cmd_word(cmd)));
	endtask

	//////////////////////////////
	// tests
	//////////////////////////////

	task automatic check_reset_state;
		@(negedge local_clk);
		assert (!out_active) else stop_with_error($sformatf(
			"mismatch out_active: got %h, expected %h", out_active, 1'b0));
		assert (out_data == 32'h0) else stop_with_error($sformatf(
			"mismatch out_data: got %h, expected %h", out_data, 32'h0));
		assert (out_datak == 4'h0) else stop_with_error($sformatf(
			"mismatch out_datak: got %h, expected %h", out_datak, 4'h0));
		wait_status(3'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1);
	endtask

	task automatic test_advertisement;
		set_ltssm(usb3_link_pkg::LT_POLLING_IDLE);
		set_ltssm(usb3_link_pkg::LT_U0);
		expect_lcmd(lgood_code(7), 100);
		for (int x = 0; x < 4; x++)
			expect_lcmd(lcrd_code(x), 20);
	endtask

	task automatic test_keepalive;
		expect_lcmd(usb3_link_pkg::LCMD_LUP, int'(usb3_link_pkg::U0L_TIMEOUT_CYCLES) + 10);
	endtask

	task automatic test_rejection;
		// bad CRC on the low copy
		send_lcmd(cmd_word(lcrd_code(0)) ^ 32'h0000_0008, 0);
		wait_cycles(6);
		wait_status(3'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1);
		// two copies with good CRCs but different commands
		send_lcmd({wire_half(lcrd_code(1)), wire_half(11'h050)}, 0);
		wait_cycles(6);
		wait_status(3'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1);
		send_lcmd(cmd_word(11'h050), 0);
		wait_status(3'd0, 1'b1, 1'b0, 1'b0, 1'b0, 10);
	endtask

	task automatic test_credits;
		send_lcmd(cmd_word(lcrd_code(0)), 0);
		wait_status(3'd1, 1'b1, 1'b0, 1'b0, 1'b0, 10);
		send_lcmd(cmd_word(lcrd_code(1)), 2);
		wait_status(3'd2, 1'b1, 1'b0, 1'b0, 1'b0, 10);
		send_lcmd(cmd_word(lcrd_code(2)), 0);
		wait_status(3'd3, 1'b1, 1'b0, 1'b0, 1'b0, 10);
		send_lcmd(cmd_word(lcrd_code(3)), 1);
		wait_status(3'd4, 1'b1, 1'b0, 1'b0, 1'b0, 10);
		// one credit too many
		send_lcmd(cmd_word(lcrd_code(0)), 0);
		wait_status(3'd4, 1'b1, 1'b1, 1'b0, 1'b0, 10);
	endtask

	task automatic test_lgood_order;
		send_lcmd(cmd_word(lgood_code(3)), 0);
		wait_cycles(6);
		wait_status(3'd4, 1'b1, 1'b1, 1'b0, 1'b0, 1);
		send_lcmd(cmd_word(lgood_code(4)), 0);
		wait_cycles(6);
		wait_status(3'd4, 1'b1, 1'b1, 1'b0, 1'b0, 1);
		// anything but LGOOD_5 now
		rnd       = $random(seed);
		wrong_seq = (rnd[2:0] == 3'd5) ? 3'd6 : rnd[2:0];
		send_lcmd(cmd_word(lgood_code(int'(wrong_seq))), 0);
		wait_status(3'd4, 1'b1, 1'b1, 1'b1, 1'b1, 10);
	endtask

	task automatic test_recovery;
		set_ltssm(usb3_link_pkg::LT_RECOVERY_IDLE);
		wait_status(3'd4, 1'b1, 1'b1, 1'b1, 1'b0, 5);
		set_ltssm(usb3_link_pkg::LT_U0);
		// no receive traffic from here on
		wait_status(3'd0, 1'b1, 1'b1, 1'b1, 1'b1,
			int'(usb3_link_pkg::U0_RECOVERY_CYCLES) + 10);
		set_ltssm(usb3_link_pkg::LT_RECOVERY_IDLE);
		wait_status(3'd0, 1'b1, 1'b1, 1'b1, 1'b0, 5);
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////
	initial begin
		seed        = 32'h5f721d1d;
		reset_n     = 1'b0;
		ltssm_state = usb3_link_pkg::LT_POLLING_IDLE;
		in_data     = 32'h0;
		in_datak    = 4'b0000;
		in_active   = 1'b0;
		wait_cycles(2);
		reset_n <= 1'b1;
		check_reset_state();
		$display("advertisement on U0 entry");
		test_advertisement();
		$display("keepalive LUP");
		test_keepalive();
		$display("rejected and undefined commands");
		test_rejection();
		$display("remote credits");
		test_credits();
		$display("LGOOD order");
		test_lgood_order();
		$display("recovery request");
		test_recovery();
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
usb3_link_pkg.sv
usb3_crc_cw.sv
usb3_lcmd_rx.sv
usb3_lcmd_tx.sv
usb3_link_timers.sv
usb3_link_ctrl.sv
usb3_link.sv
tb_usb3_link.sv

//--- Makefile
# Verilator build and run of the usb3 link command testbench

TOP := tb_usb3_link

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee run.log
	grep -q '^>>> PASS$$' run.log

lint:
	verilator --lint-only -Wall --timing -f list.f --top-module usb3_link

clean:
	rm -rf obj_dir run.log
